// File: source/axil_regs_pkg.sv
// AXI4-Lite register bank definitions
package axil_regs_pkg;

  // Response codes used on the B and R channels.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Data returned on every refused read.
  localparam logic [31:0] ERR_RDATA = 32'hBA5E1E55;

  // Prot field layout.
  localparam int unsigned PROT_W        = 3;
  localparam int unsigned PROT_PRIV_BIT = 0;
  localparam int unsigned PROT_SECU_BIT = 1;

  // Default widths for the top level.
  localparam int unsigned DEF_ADDR_W = 32;
  localparam int unsigned DEF_DATA_W = 32;
  localparam int unsigned DEF_REG_W  = 32;

  // Maps a bus address onto a register index relative to the base.
  // Returns the valid bit, the index comes back through idx.
  function automatic logic addr_decode(
    input  logic [63:0] addr,
    input  logic [63:0] base,
    input  int unsigned num_regs,
    input  int unsigned word_bytes,
    output int unsigned idx
  );
    logic [63:0] offset;
    logic [63:0] window;
    // Below the base the offset wraps and lands outside the window.
    offset = addr - base;
    window = 64'(num_regs) * 64'(word_bytes);
    // Any byte inside a bus word selects the same register.
    idx    = 32'(offset / 64'(word_bytes));
    return offset < window;
  endfunction

endpackage

// File: source/resp_spill.sv
// Two-slot response spill buffer
`timescale 1ns/1ps

module resp_spill #(
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // Push side, strobe plus room.
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             room_o,
  // Pop side, a plain valid/ready channel.
  output logic             pop_valid_o,
  input  logic             pop_ready_i,
  output logic [WIDTH-1:0] pop_data_o
);

  // Slot a drives the outputs, slot b catches the overflow.
  logic             a_full;
  logic             b_full;
  logic [WIDTH-1:0] a_data;
  logic [WIDTH-1:0] b_data;

  logic             push;
  logic             pop;
  logic             a_load;

  // Room while the spill slot is empty.
  assign room_o      = !b_full;
  assign pop_valid_o = a_full;
  assign pop_data_o  = a_data;

  // Push is only taken while there is room.
  assign push   = push_i && !b_full;
  assign pop    = a_full && pop_ready_i;
  // Output slot refills when empty or when its item leaves.
  assign a_load = !a_full || pop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      if (a_load) begin
        a_full <= b_full || push;
      end
      // Spill slot drains into slot a first.
      if (b_full && a_load) begin
        b_full <= 1'b0;
      end else if (push && !a_load) begin
        b_full <= 1'b1;
      end
    end
  end

  // Payload slots carry no reset.
  always_ff @(posedge clk_i) begin
    if (a_load) begin
      // Oldest item moves forward.
      a_data <= b_full ? b_data : push_data_i;
    end
    if (push && !a_load) begin
      b_data <= push_data_i;
    end
  end

endmodule

// File: source/axil_write_ctrl.sv
// AXI4-Lite write controller
`timescale 1ns/1ps

module axil_write_ctrl import axil_regs_pkg::*; #(
  parameter int unsigned           NUM_REGS  = 4,
  parameter int unsigned           ADDR_W    = 32,
  parameter int unsigned           DATA_W    = 32,
  parameter bit                    PRIV_ONLY = 1'b0,
  parameter bit                    SECU_ONLY = 1'b0,
  parameter logic [NUM_REGS-1:0]   RO_MASK   = '0,
  parameter int unsigned           IDX_W     = 2
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [ADDR_W-1:0]   base_addr_i,
  input  logic                aw_valid_i,
  input  logic [ADDR_W-1:0]   aw_addr_i,
  input  logic [PROT_W-1:0]   aw_prot_i,
  input  logic                w_valid_i,
  input  logic [DATA_W-1:0]   w_data_i,
  input  logic [DATA_W/8-1:0] w_strb_i,
  input  logic [NUM_REGS-1:0] load_i,
  input  logic                b_room_i,
  output logic                aw_ready_o,
  output logic                w_ready_o,
  output logic                b_push_o,
  output axil_resp_e          b_resp_o,
  output logic                wr_en_o,
  output logic [IDX_W-1:0]    wr_idx_o,
  output logic [DATA_W-1:0]   wr_data_o,
  output logic [DATA_W/8-1:0] wr_strb_o
);

  // Per-cycle decision.
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACCEPT,
    WR_REFUSE,
    WR_STALL
  } wr_decision_e;

  wr_decision_e decision;
  logic         rst_done;
  logic         dec_valid;
  int unsigned  dec_idx;
  logic         prot_ok;
  logic         ro_hit;

  // Holds the handshake off until the first edge after reset.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_done <= 1'b0;
    end else begin
      rst_done <= 1'b1;
    end
  end

  always_comb begin
    dec_valid = addr_decode(64'(aw_addr_i), 64'(base_addr_i), NUM_REGS, DATA_W / 8, dec_idx);
  end

  assign wr_idx_o  = IDX_W'(dec_idx);
  assign prot_ok   = (!PRIV_ONLY || aw_prot_i[PROT_PRIV_BIT]) &&
                     (!SECU_ONLY || aw_prot_i[PROT_SECU_BIT]);
  // Only look up the mask for an index inside the window.
  assign ro_hit    = dec_valid ? RO_MASK[wr_idx_o] : 1'b0;
  assign wr_data_o = w_data_i;
  assign wr_strb_o = w_strb_i;

  // AW and W are taken together, and only with room for the response.
  always_comb begin
    decision = WR_IDLE;
    if (rst_done && aw_valid_i && w_valid_i && b_room_i) begin
      if (!dec_valid || !prot_ok || ro_hit) begin
        decision = WR_REFUSE;
      end else if (load_i[wr_idx_o]) begin
        // Local load owns the register this cycle.
        decision = WR_STALL;
      end else begin
        decision = WR_ACCEPT;
      end
    end
  end

  always_comb begin
    aw_ready_o = 1'b0;
    b_push_o   = 1'b0;
    b_resp_o   = RESP_SLVERR;
    wr_en_o    = 1'b0;
    case (decision)
      WR_ACCEPT: begin
        aw_ready_o = 1'b1;
        b_push_o   = 1'b1;
        b_resp_o   = RESP_OKAY;
        wr_en_o    = 1'b1;
      end
      // Refused writes still complete, with an error.
      WR_REFUSE: begin
        aw_ready_o = 1'b1;
        b_push_o   = 1'b1;
      end
      default: begin
        aw_ready_o = 1'b0;
      end
    endcase
  end

  // Both channels handshake in the same cycle.
  assign w_ready_o = aw_ready_o;

endmodule

// File: source/axil_read_ctrl.sv
// AXI4-Lite read controller
`timescale 1ns/1ps

module axil_read_ctrl import axil_regs_pkg::*; #(
  parameter int unsigned NUM_REGS  = 4,
  parameter int unsigned ADDR_W    = 32,
  parameter int unsigned DATA_W    = 32,
  parameter int unsigned REG_W     = 32,
  parameter bit          PRIV_ONLY = 1'b0,
  parameter bit          SECU_ONLY = 1'b0,
  parameter int unsigned IDX_W     = 2
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [ADDR_W-1:0]              base_addr_i,
  input  logic                           ar_valid_i,
  input  logic [ADDR_W-1:0]              ar_addr_i,
  input  logic [PROT_W-1:0]              ar_prot_i,
  input  logic [NUM_REGS-1:0][REG_W-1:0] reg_q_i,
  input  logic                           r_room_i,
  output logic                           ar_ready_o,
  output logic                           r_push_o,
  output logic [DATA_W-1:0]              r_data_o,
  output axil_resp_e                     r_resp_o,
  output logic [IDX_W-1:0]               rd_idx_o,
  output logic                           rd_active_o
);

  logic        rst_done;
  logic        dec_valid;
  int unsigned dec_idx;
  logic        prot_ok;
  logic        rd_ok;

  // Ready stays low until the first edge after reset.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_done <= 1'b0;
    end else begin
      rst_done <= 1'b1;
    end
  end

  always_comb begin
    dec_valid = addr_decode(64'(ar_addr_i), 64'(base_addr_i), NUM_REGS, DATA_W / 8, dec_idx);
  end

  assign rd_idx_o = IDX_W'(dec_idx);
  assign prot_ok  = (!PRIV_ONLY || ar_prot_i[PROT_PRIV_BIT]) &&
                    (!SECU_ONLY || ar_prot_i[PROT_SECU_BIT]);
  assign rd_ok    = dec_valid && prot_ok;

  // AR ready mirrors the spill room.
  assign ar_ready_o = r_room_i && rst_done;
  // Push follows AR valid, qualified by the handshake.
  assign r_push_o   = ar_valid_i && ar_ready_o;

  // Register zero-extended, or the error word.
  assign r_data_o = rd_ok ? DATA_W'(reg_q_i[rd_idx_o]) : DATA_W'(ERR_RDATA);
  assign r_resp_o = rd_ok ? RESP_OKAY : RESP_SLVERR;

  // Flags only successful reads.
  assign rd_active_o = r_push_o && rd_ok;

endmodule

// File: source/reg_array.sv
// Control register storage
`timescale 1ns/1ps

module reg_array #(
  parameter int unsigned                    NUM_REGS = 4,
  parameter int unsigned                    DATA_W   = 32,
  parameter int unsigned                    REG_W    = 32,
  parameter logic [NUM_REGS-1:0][REG_W-1:0] RST_VAL  = '0,
  parameter int unsigned                    IDX_W    = 2
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [NUM_REGS-1:0]            load_i,
  input  logic [NUM_REGS-1:0][REG_W-1:0] load_data_i,
  input  logic                           wr_en_i,
  input  logic [IDX_W-1:0]               wr_idx_i,
  input  logic [DATA_W-1:0]              wr_data_i,
  input  logic [DATA_W/8-1:0]            wr_strb_i,
  output logic [NUM_REGS-1:0][REG_W-1:0] reg_q_o
);

  // Bus write merged into the current value, byte by byte.
  logic [NUM_REGS-1:0][REG_W-1:0] wr_merged;

  always_comb begin
    for (int r = 0; r < NUM_REGS; r++) begin
      wr_merged[r] = reg_q_o[r];
      for (int b = 0; b < REG_W; b++) begin
        // Bus bits above REG_W are dropped.
        if (wr_strb_i[b / 8]) begin
          wr_merged[r][b] = wr_data_i[b];
        end
      end
    end
  end

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        reg_q_o[i] <= RST_VAL[i];
      end else if (load_i[i]) begin
        // Local load wins over the bus.
        reg_q_o[i] <= load_data_i[i];
      end else if (wr_en_i && (wr_idx_i == IDX_W'(i))) begin
        reg_q_o[i] <= wr_merged[i];
      end
    end
  end

endmodule

// File: source/axil_regs_top.sv
// AXI4-Lite control register bank
`timescale 1ns/1ps

module axil_regs_top import axil_regs_pkg::*; #(
  parameter int unsigned                    NUM_REGS  = 4,
  parameter int unsigned                    ADDR_W    = DEF_ADDR_W,
  parameter int unsigned                    DATA_W    = DEF_DATA_W,
  parameter int unsigned                    REG_W     = DEF_REG_W,
  parameter bit                             PRIV_ONLY = 1'b0,
  parameter bit                             SECU_ONLY = 1'b0,
  parameter logic [NUM_REGS-1:0]            RO_MASK   = '0,
  parameter logic [NUM_REGS-1:0][REG_W-1:0] RST_VAL   = '0,
  // Derived from NUM_REGS.
  parameter int unsigned                    IDX_W     = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [ADDR_W-1:0]              base_addr_i,
  // Write address and data.
  input  logic                           aw_valid_i,
  output logic                           aw_ready_o,
  input  logic [ADDR_W-1:0]              aw_addr_i,
  input  logic [PROT_W-1:0]              aw_prot_i,
  input  logic                           w_valid_i,
  output logic                           w_ready_o,
  input  logic [DATA_W-1:0]              w_data_i,
  input  logic [DATA_W/8-1:0]            w_strb_i,
  // Write response.
  output logic                           b_valid_o,
  input  logic                           b_ready_i,
  output axil_resp_e                     b_resp_o,
  // Read address and data.
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  input  logic [ADDR_W-1:0]              ar_addr_i,
  input  logic [PROT_W-1:0]              ar_prot_i,
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  output logic [DATA_W-1:0]              r_data_o,
  output axil_resp_e                     r_resp_o,
  // Local side.
  input  logic [NUM_REGS-1:0]            load_i,
  input  logic [NUM_REGS-1:0][REG_W-1:0] load_data_i,
  output logic [NUM_REGS-1:0][REG_W-1:0] reg_q_o,
  output logic [IDX_W-1:0]               wr_idx_o,
  output logic                           wr_active_o,
  output logic [IDX_W-1:0]               rd_idx_o,
  output logic                           rd_active_o
);

  // Write side to B spill and register array.
  logic                b_push;
  logic                b_room;
  axil_resp_e          b_resp_in;
  logic [1:0]          b_resp_out;
  logic [DATA_W-1:0]   wr_data;
  logic [DATA_W/8-1:0] wr_strb;

  // Read side to R spill, payload is data then response.
  logic                r_push;
  logic                r_room;
  logic [DATA_W-1:0]   r_data_in;
  axil_resp_e          r_resp_in;
  logic [DATA_W+1:0]   r_pop_data;

  axil_write_ctrl #(
    .NUM_REGS  (NUM_REGS),
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .PRIV_ONLY (PRIV_ONLY),
    .SECU_ONLY (SECU_ONLY),
    .RO_MASK   (RO_MASK),
    .IDX_W     (IDX_W)
  ) u_write_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .base_addr_i (base_addr_i),
    .aw_valid_i  (aw_valid_i),
    .aw_addr_i   (aw_addr_i),
    .aw_prot_i   (aw_prot_i),
    .w_valid_i   (w_valid_i),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .load_i      (load_i),
    .b_room_i    (b_room),
    .aw_ready_o  (aw_ready_o),
    .w_ready_o   (w_ready_o),
    .b_push_o    (b_push),
    .b_resp_o    (b_resp_in),
    .wr_en_o     (wr_active_o),
    .wr_idx_o    (wr_idx_o),
    .wr_data_o   (wr_data),
    .wr_strb_o   (wr_strb)
  );

  axil_read_ctrl #(
    .NUM_REGS  (NUM_REGS),
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .REG_W     (REG_W),
    .PRIV_ONLY (PRIV_ONLY),
    .SECU_ONLY (SECU_ONLY),
    .IDX_W     (IDX_W)
  ) u_read_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .base_addr_i (base_addr_i),
    .ar_valid_i  (ar_valid_i),
    .ar_addr_i   (ar_addr_i),
    .ar_prot_i   (ar_prot_i),
    .reg_q_i     (reg_q_o),
    .r_room_i    (r_room),
    .ar_ready_o  (ar_ready_o),
    .r_push_o    (r_push),
    .r_data_o    (r_data_in),
    .r_resp_o    (r_resp_in),
    .rd_idx_o    (rd_idx_o),
    .rd_active_o (rd_active_o)
  );

  reg_array #(
    .NUM_REGS (NUM_REGS),
    .DATA_W   (DATA_W),
    .REG_W    (REG_W),
    .RST_VAL  (RST_VAL),
    .IDX_W    (IDX_W)
  ) u_reg_array (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .load_i      (load_i),
    .load_data_i (load_data_i),
    .wr_en_i     (wr_active_o),
    .wr_idx_i    (wr_idx_o),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .reg_q_o     (reg_q_o)
  );

  // One cycle of decoupling on B.
  resp_spill #(
    .WIDTH (2)
  ) b_spill (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .push_i      (b_push),
    .push_data_i (b_resp_in),
    .room_o      (b_room),
    .pop_valid_o (b_valid_o),
    .pop_ready_i (b_ready_i),
    .pop_data_o  (b_resp_out)
  );

  // One cycle of decoupling on R.
  resp_spill #(
    .WIDTH (DATA_W + 2)
  ) r_spill (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .push_i      (r_push),
    .push_data_i ({r_data_in, r_resp_in}),
    .room_o      (r_room),
    .pop_valid_o (r_valid_o),
    .pop_ready_i (r_ready_i),
    .pop_data_o  (r_pop_data)
  );

  assign b_resp_o = axil_resp_e'(b_resp_out);
  assign r_data_o = r_pop_data[DATA_W+1:2];
  assign r_resp_o = axil_resp_e'(r_pop_data[1:0]);

endmodule

// File: bench/axil_regs_chk.sv
// Register bank protocol assertions
`timescale 1ns/1ps

module axil_regs_chk #(
  parameter int unsigned         NUM_REGS = 4,
  parameter int unsigned         DATA_W   = 32,
  parameter int unsigned         REG_W    = 32,
  parameter int unsigned         IDX_W    = 2,
  parameter logic [NUM_REGS-1:0] RO_MASK  = '0
) (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           aw_ready_i,
  input logic                           w_ready_i,
  input logic [DATA_W-1:0]              w_data_i,
  input logic [DATA_W/8-1:0]            w_strb_i,
  input logic                           b_valid_i,
  input logic                           b_ready_i,
  input logic [1:0]                     b_resp_i,
  input logic                           r_valid_i,
  input logic                           r_ready_i,
  input logic [DATA_W-1:0]              r_data_i,
  input logic [1:0]                     r_resp_i,
  input logic [NUM_REGS-1:0][REG_W-1:0] reg_q_i,
  input logic [IDX_W-1:0]               wr_idx_i,
  input logic                           wr_active_i,
  input logic                           rd_active_i
);

  int               fail_cnt = 0;
  logic [REG_W-1:0] wr_expect;
  logic [REG_W-1:0] wr_expect_q;
  logic [IDX_W-1:0] wr_idx_q;

  // Strobed bus data merged into the addressed register.
  always_comb begin
    wr_expect = reg_q_i[wr_idx_i];
    for (int b = 0; b < REG_W / 8; b++) begin
      if (w_strb_i[b]) begin
        wr_expect[b*8 +: 8] = w_data_i[b*8 +: 8];
      end
    end
  end

  // Last cycle's write target.
  always_ff @(posedge clk_i) begin
    wr_idx_q    <= wr_idx_i;
    wr_expect_q <= wr_expect;
  end

  b_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else begin $error("B response changed while stalled"); fail_cnt++; end

  r_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
    else begin $error("R response changed while stalled"); fail_cnt++; end

  // Write address and data handshake together.
  aw_w_ready_a: assert property (@(posedge clk_i) aw_ready_i == w_ready_i)
    else begin $error("aw_ready and w_ready differ"); fail_cnt++; end

  ro_write_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_active_i |-> !RO_MASK[wr_idx_i])
    else begin $error("Write accepted into a read-only register"); fail_cnt++; end

  wr_update_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_active_i |=> reg_q_i[wr_idx_q] == wr_expect_q)
    else begin $error("Register did not take the strobed write data"); fail_cnt++; end

  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !b_valid_i && !r_valid_i && !wr_active_i && !rd_active_i)
    else begin $error("Valid or active output high during reset"); fail_cnt++; end

endmodule

bind axil_regs_top axil_regs_chk #(
  .NUM_REGS (NUM_REGS),
  .DATA_W   (DATA_W),
  .REG_W    (REG_W),
  .IDX_W    (IDX_W),
  .RO_MASK  (RO_MASK)
) chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .aw_ready_i  (aw_ready_o),
  .w_ready_i   (w_ready_o),
  .w_data_i    (w_data_i),
  .w_strb_i    (w_strb_i),
  .b_valid_i   (b_valid_o),
  .b_ready_i   (b_ready_i),
  .b_resp_i    (b_resp_o),
  .r_valid_i   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .r_data_i    (r_data_o),
  .r_resp_i    (r_resp_o),
  .reg_q_i     (reg_q_o),
  .wr_idx_i    (wr_idx_o),
  .wr_active_i (wr_active_o),
  .rd_active_i (rd_active_o)
);

// File: bench/axil_regs_tb.sv
// Register bank testbench
`timescale 1ns/1ps

module axil_regs_tb import axil_regs_pkg::*; ();

  localparam int unsigned                    NUM_REGS = 4;
  localparam int unsigned                    ADDR_W   = 12;
  localparam int unsigned                    DATA_W   = 32;
  localparam int unsigned                    REG_W    = 16;
  localparam int unsigned                    IDX_W    = 2;
  localparam logic [NUM_REGS-1:0]            RO_MASK  = 4'b1000;
  localparam logic [NUM_REGS-1:0][REG_W-1:0] RST_VAL  =
    {16'h4D04, 16'h3C03, 16'h2B02, 16'h1A01};
  localparam logic [ADDR_W-1:0]              BASE     = 12'h100;
  // Upper two lanes of these strobes lie above the register width.
  localparam logic [3:0]                     PART_STRB [3] = '{4'b0001, 4'b0110, 4'b1010};
  // Well above the length of all tests.
  localparam int unsigned                    TIMEOUT_CYCLES = 2000;

  logic                           clk;
  logic                           arst_n;
  logic [ADDR_W-1:0]              base_addr;
  logic                           aw_valid;
  logic                           aw_ready;
  logic [ADDR_W-1:0]              aw_addr;
  logic [PROT_W-1:0]              aw_prot;
  logic                           w_valid;
  logic                           w_ready;
  logic [DATA_W-1:0]              w_data;
  logic [DATA_W/8-1:0]            w_strb;
  logic                           b_valid;
  logic                           b_ready;
  axil_resp_e                     b_resp;
  logic                           ar_valid;
  logic                           ar_ready;
  logic [ADDR_W-1:0]              ar_addr;
  logic [PROT_W-1:0]              ar_prot;
  logic                           r_valid;
  logic                           r_ready;
  logic [DATA_W-1:0]              r_data;
  axil_resp_e                     r_resp;
  logic [NUM_REGS-1:0]            load;
  logic [NUM_REGS-1:0][REG_W-1:0] load_data;
  logic [NUM_REGS-1:0][REG_W-1:0] reg_q;
  logic [IDX_W-1:0]               wr_idx;
  logic                           wr_active;
  logic [IDX_W-1:0]               rd_idx;
  logic                           rd_active;

  // Shadow copy of the register state.
  logic [REG_W-1:0]  model_q [NUM_REGS];
  // Expected responses in arrival order.
  axil_resp_e        exp_b_q [$];
  logic [DATA_W-1:0] exp_r_data_q [$];
  axil_resp_e        exp_r_resp_q [$];

  integer      seed = 32'he984;
  int unsigned err_cnt = 0;
  int unsigned check_cnt = 0;
  int unsigned test_cnt = 0;
  int unsigned test_err_base = 0;
  int unsigned cycle_cnt = 0;

  axil_regs_top #(
    .NUM_REGS  (NUM_REGS),
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .REG_W     (REG_W),
    .PRIV_ONLY (1'b1),
    .SECU_ONLY (1'b0),
    .RO_MASK   (RO_MASK),
    .RST_VAL   (RST_VAL)
  ) dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .base_addr_i (base_addr),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_addr_i   (aw_addr),
    .aw_prot_i   (aw_prot),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_data_i    (w_data),
    .w_strb_i    (w_strb),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .b_resp_o    (b_resp),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_addr_i   (ar_addr),
    .ar_prot_i   (ar_prot),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_data_o    (r_data),
    .r_resp_o    (r_resp),
    .load_i      (load),
    .load_data_i (load_data),
    .reg_q_o     (reg_q),
    .wr_idx_o    (wr_idx),
    .wr_active_o (wr_active),
    .rd_idx_o    (rd_idx),
    .rd_active_o (rd_active)
  );

  always #10 clk = ~clk;

  // Bus address of a byte inside a register's word.
  function automatic logic [ADDR_W-1:0] reg_addr(input int unsigned idx, input int unsigned off);
    return ADDR_W'(32'(BASE) + idx * (DATA_W / 8) + off);
  endfunction

  // Byte lanes above the register width have no effect.
  function automatic logic [REG_W-1:0] strobe_merge(input logic [REG_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [DATA_W/8-1:0] strb);
    logic [REG_W-1:0] res;
    res = old;
    for (int b = 0; b < REG_W / 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] want);
    check_cnt++;
    assert (got === want) else begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  task automatic check_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      check_val("reg_q", 32'(reg_q[i]), 32'(model_q[i]));
    end
  endtask

  // Issues AW and W together and waits for the handshake.
  task automatic write_req(input logic [ADDR_W-1:0] addr, input logic [PROT_W-1:0] prot,
                           input logic [DATA_W-1:0] data, input logic [DATA_W/8-1:0] strb,
                           input bit exp_ok, input int unsigned idx);
    @(posedge clk);
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    aw_prot  <= prot;
    w_valid  <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    @(negedge clk);
    while (!aw_ready) begin
      @(negedge clk);
    end
    // Active flag marks only accepted writes.
    check_val("wr_active", 32'(wr_active), 32'(exp_ok));
    if (exp_ok) begin
      check_val("wr_idx", 32'(wr_idx), idx);
      model_q[idx] = strobe_merge(model_q[idx], data, strb);
    end
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
  endtask

  task automatic wait_b(input axil_resp_e want);
    @(negedge clk);
    while (!b_valid) begin
      @(negedge clk);
    end
    check_val("b_resp", 32'(b_resp), 32'(want));
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [PROT_W-1:0] prot,
                           input logic [DATA_W-1:0] data, input logic [DATA_W/8-1:0] strb,
                           input bit exp_ok, input int unsigned idx);
    write_req(addr, prot, data, strb, exp_ok, idx);
    wait_b(exp_ok ? RESP_OKAY : RESP_SLVERR);
  endtask

  task automatic read_req(input logic [ADDR_W-1:0] addr, input logic [PROT_W-1:0] prot,
                          input bit exp_ok, input int unsigned idx);
    @(posedge clk);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    ar_prot  <= prot;
    @(negedge clk);
    while (!ar_ready) begin
      @(negedge clk);
    end
    check_val("rd_active", 32'(rd_active), 32'(exp_ok));
    if (exp_ok) begin
      check_val("rd_idx", 32'(rd_idx), idx);
    end
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_r(input logic [DATA_W-1:0] want_data, input axil_resp_e want_resp);
    @(negedge clk);
    while (!r_valid) begin
      @(negedge clk);
    end
    check_val("r_data", r_data, want_data);
    check_val("r_resp", 32'(r_resp), 32'(want_resp));
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [PROT_W-1:0] prot,
                          input bit exp_ok, input int unsigned idx);
    logic [DATA_W-1:0] want;
    // Zero-extended register, or the error word.
    want = exp_ok ? DATA_W'(model_q[idx]) : ERR_RDATA;
    read_req(addr, prot, exp_ok, idx);
    wait_r(want, exp_ok ? RESP_OKAY : RESP_SLVERR);
  endtask

  // Collects queued B responses in order once ready is high.
  task automatic drain_b(input int n);
    int         got;
    axil_resp_e want;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      if (b_valid) begin
        want = exp_b_q.pop_front();
        check_val("b_resp in order", 32'(b_resp), 32'(want));
        got++;
      end
    end
  endtask

  task automatic drain_r(input int n);
    int                got;
    logic [DATA_W-1:0] want_data;
    axil_resp_e        want_resp;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      if (r_valid) begin
        want_data = exp_r_data_q.pop_front();
        want_resp = exp_r_resp_q.pop_front();
        check_val("r_data in order", r_data, want_data);
        check_val("r_resp in order", 32'(r_resp), 32'(want_resp));
        got++;
      end
    end
  endtask

  // Run limit.
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] data;
    logic [REG_W-1:0]  ld_val;
    clk       = 1'b0;
    arst_n    = 1'b0;
    base_addr = BASE;
    aw_valid  = 1'b0;
    aw_addr   = '0;
    aw_prot   = '0;
    w_valid   = 1'b0;
    w_data    = '0;
    w_strb    = '0;
    b_ready   = 1'b1;
    ar_valid  = 1'b0;
    ar_addr   = '0;
    ar_prot   = '0;
    r_ready   = 1'b1;
    load      = '0;
    load_data = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_q[i] = RST_VAL[i];
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Reset values.
    for (int i = 0; i < NUM_REGS; i++) begin
      bus_read(reg_addr(i, 0), 3'b001, 1'b1, i);
    end
    check_regs();
    finish_test("reset values");

    // Partial strobes at varying byte offsets inside each word.
    for (int n = 0; n < 3; n++) begin
      data = $random(seed);
      bus_write(reg_addr(n, n), 3'b001, data, PART_STRB[n], 1'b1, n);
    end
    for (int n = 0; n < 3; n++) begin
      bus_read(reg_addr(n, 3 - n), 3'b011, 1'b1, n);
    end
    check_regs();
    finish_test("strobed writes");

    // Outside the window, read-only target, unprivileged access.
    data = $random(seed);
    bus_write(reg_addr(4, 0), 3'b001, data, 4'hF, 1'b0, 0);
    bus_write(12'h0FC, 3'b001, data, 4'hF, 1'b0, 0);
    bus_write(reg_addr(3, 0), 3'b001, data, 4'hF, 1'b0, 0);
    bus_write(reg_addr(0, 0), 3'b010, data, 4'hF, 1'b0, 0);
    bus_read(reg_addr(4, 0), 3'b001, 1'b0, 0);
    bus_read(12'h0FC, 3'b001, 1'b0, 0);
    bus_read(reg_addr(1, 0), 3'b000, 1'b0, 0);
    bus_read(reg_addr(3, 0), 3'b001, 1'b1, 3);
    check_regs();
    finish_test("refused accesses");

    // Held load stalls a write to the same register.
    ld_val = $random(seed);
    data   = $random(seed);
    fork
      begin
        @(posedge clk);
        load[1]      <= 1'b1;
        load_data[1] <= ld_val;
        model_q[1]   = ld_val;
        // Load value lands on the next edge.
        @(posedge clk);
        repeat (4) begin
          @(negedge clk);
          check_val("aw_ready under load", 32'(aw_ready), 32'd0);
          check_val("reg_q under load", 32'(reg_q[1]), 32'(ld_val));
        end
        @(posedge clk);
        load[1] <= 1'b0;
      end
      bus_write(reg_addr(1, 0), 3'b001, data, 4'hF, 1'b1, 1);
    join
    bus_read(reg_addr(1, 0), 3'b001, 1'b1, 1);
    // Loads ignore the read-only mask.
    ld_val = $random(seed);
    @(posedge clk);
    load[3]      <= 1'b1;
    load_data[3] <= ld_val;
    model_q[3]   = ld_val;
    @(posedge clk);
    load[3] <= 1'b0;
    bus_read(reg_addr(3, 0), 3'b001, 1'b1, 3);
    check_regs();
    finish_test("local loads");

    // Back-pressure on B where only two responses fit.
    @(posedge clk);
    b_ready <= 1'b0;
    r_ready <= 1'b0;
    exp_b_q.push_back(RESP_OKAY);
    exp_b_q.push_back(RESP_SLVERR);
    exp_b_q.push_back(RESP_OKAY);
    write_req(reg_addr(0, 0), 3'b001, $random(seed), 4'hF, 1'b1, 0);
    write_req(reg_addr(3, 0), 3'b001, $random(seed), 4'hF, 1'b0, 0);
    fork
      write_req(reg_addr(2, 0), 3'b001, $random(seed), 4'h3, 1'b1, 2);
      begin
        @(posedge clk);
        repeat (3) begin
          @(negedge clk);
          check_val("aw_ready with B full", 32'(aw_ready), 32'd0);
        end
        @(posedge clk);
        b_ready <= 1'b1;
        drain_b(3);
      end
    join
    // Same on R.
    exp_r_data_q.push_back(DATA_W'(model_q[0]));
    exp_r_resp_q.push_back(RESP_OKAY);
    exp_r_data_q.push_back(ERR_RDATA);
    exp_r_resp_q.push_back(RESP_SLVERR);
    exp_r_data_q.push_back(DATA_W'(model_q[2]));
    exp_r_resp_q.push_back(RESP_OKAY);
    read_req(reg_addr(0, 0), 3'b001, 1'b1, 0);
    read_req(reg_addr(4, 0), 3'b001, 1'b0, 0);
    fork
      read_req(reg_addr(2, 0), 3'b001, 1'b1, 2);
      begin
        @(posedge clk);
        repeat (3) begin
          @(negedge clk);
          check_val("ar_ready with R full", 32'(ar_ready), 32'd0);
        end
        @(posedge clk);
        r_ready <= 1'b1;
        drain_r(3);
      end
    join
    check_regs();
    finish_test("back-pressure");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, dut.chk.fail_cnt);
    if (err_cnt == 0 && dut.chk.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
source/axil_regs_pkg.sv
source/resp_spill.sv
source/axil_write_ctrl.sv
source/axil_read_ctrl.sv
source/reg_array.sv
source/axil_regs_top.sv
bench/axil_regs_chk.sv
bench/axil_regs_tb.sv

// File: Makefile
TOP := axil_regs_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
